// File: logic/adc_frontend.sv
/* input register for the raw ADC words, then conversion from unsigned
   negative slope to two's complement samples, one cycle latency */
module adc_frontend #(
  parameter int NUM_CH = 2
) (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,
  input  logic [NUM_CH-1:0][rp_pkg::ADC_W-1:0] raw_i,   // pins, packed per channel
  output rp_pkg::sample_t                      smp_o [NUM_CH]
);
  import rp_pkg::*;

  logic [NUM_CH-1:0][ADC_W-1:0] raw_q;  // io register

  ////////////////////////////////////////
  // capture
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      raw_q <= {NUM_CH{RAW_ZERO}};  // reads as sample 0
    else
      raw_q <= raw_i;
  end

  ////////////////////////////////////////
  // conversion
  ////////////////////////////////////////

  // sign bit kept, magnitude bits inverted
  for (genvar ch = 0; ch < NUM_CH; ch++)
  begin : g_conv
    assign smp_o[ch] = sample_t'(flip_slope(raw_q[ch]));
  end

endmodule

// File: logic/channel_path.sv
/* one channel: offset and enable registers on the bus, loopback select
   and saturating offset add into a registered result */
module channel_path (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  // register bus
  input  logic             req_i,
  input  rp_pkg::bus_req_t cmd_i,
  output logic             ack_o,
  output rp_pkg::bus_rsp_t rsp_o,
  // samples
  input  logic             loop_i,  // take own result instead of ADC
  input  rp_pkg::sample_t  smp_i,
  output rp_pkg::sample_t  res_o
);
  import rp_pkg::*;

  localparam sample_t SMP_MAX = {1'b0, {(ADC_W-1){1'b1}}};
  localparam sample_t SMP_MIN = {1'b1, {(ADC_W-1){1'b0}}};

  logic [REGION_LSB-1:0] ofs;
  logic                  acc;     // first cycle of access
  logic                  wr;
  logic [BUS_W-1:0]      rd_dat;
  logic                  rd_err;
  logic                  ack_q;
  bus_rsp_t              rsp_q;
  sample_t               off_q;   // signed offset
  logic                  en_q;    // output enable
  sample_t               src;     // selected input sample
  logic [ADC_W:0]        sum;     // one guard bit
  sample_t               sat;
  sample_t               res_q;

  ////////////////////////////////////////
  // register slave
  ////////////////////////////////////////

  assign ofs = cmd_i.addr[REGION_LSB-1:0];
  assign acc = req_i & ~ack_q;
  assign wr  = acc & cmd_i.wen;

  always_comb
  begin
    rd_dat = '0;
    rd_err = 1'b0;
    case (ofs)
      REG_OFFSET: rd_dat = {{(BUS_W-ADC_W){off_q[ADC_W-1]}}, off_q};  // sign extended
      REG_ENABLE: rd_dat = BUS_W'(en_q);
      default:    rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (acc)
      rsp_q <= '{rdata: rd_dat, err: rd_err};
  end

  ////////////////////////////////////////
  // offset add with saturation
  ////////////////////////////////////////

  assign src = loop_i ? res_q : smp_i;
  assign sum = {src[ADC_W-1], src} + {off_q[ADC_W-1], off_q};

  always_comb
  begin
    if (sum[ADC_W] != sum[ADC_W-1])
      sat = sum[ADC_W] ? SMP_MIN : SMP_MAX;  // overflow, clamp by true sign
    else
      sat = sum[ADC_W-1:0];
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      off_q <= '0;
      en_q  <= 1'b0;
      res_q <= '0;
    end
    else
    begin
      ack_q <= req_i;
      if (wr && ofs == REG_OFFSET)
        off_q <= cmd_i.wdata[ADC_W-1:0];
      if (wr && ofs == REG_ENABLE)
        en_q <= cmd_i.wdata[0];
      res_q <= en_q ? sat : '0;  // disabled channel outputs zero
    end
  end

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;
  assign res_o = res_q;

endmodule

// File: logic/dac_backend.sv
/* converts channel results back to the DAC unsigned negative slope
   format and registers the DAC pins, one cycle latency */
module dac_backend #(
  parameter int NUM_CH = 2
) (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,
  input  rp_pkg::sample_t                      res_i [NUM_CH],
  output logic [NUM_CH-1:0][rp_pkg::ADC_W-1:0] raw_o    // DAC pins
);
  import rp_pkg::*;

  logic [NUM_CH-1:0][ADC_W-1:0] dac_d;  // converted, before pin register

  ////////////////////////////////////////
  // conversion
  ////////////////////////////////////////

  for (genvar ch = 0; ch < NUM_CH; ch++)
  begin : g_conv
    assign dac_d[ch] = flip_slope(res_i[ch]);  // invert all but sign
  end

  ////////////////////////////////////////
  // pin register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      raw_o <= {NUM_CH{RAW_ZERO}};  // mid scale
    else
      raw_o <= dac_d;
  end

endmodule

// File: logic/housekeeping_regs.sv
/* housekeeping register slave: loopback switch, led pattern and a
   read-only board id, answered with one cycle req to ack */
module housekeeping_regs #(
  parameter int LED_W = 8
) (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic             req_i,
  input  rp_pkg::bus_req_t cmd_i,
  output logic             ack_o,
  output rp_pkg::bus_rsp_t rsp_o,
  output logic             loop_o,   // digital loopback to all channels
  output logic [LED_W-1:0] led_o
);
  import rp_pkg::*;

  logic [REGION_LSB-1:0] ofs;      // offset inside region
  logic                  acc;      // first cycle of access
  logic                  wr;       // write strobe, same edge as ack rise
  logic [BUS_W-1:0]      rd_dat;
  logic                  rd_err;
  logic                  ack_q;
  bus_rsp_t              rsp_q;
  logic                  loop_q;
  logic [LED_W-1:0]      led_q;

  assign ofs = cmd_i.addr[REGION_LSB-1:0];
  assign acc = req_i & ~ack_q;
  assign wr  = acc & cmd_i.wen;

  // read mux and error decode
  always_comb
  begin
    rd_dat = '0;
    rd_err = 1'b0;
    case (ofs)
      REG_LOOP: rd_dat = BUS_W'(loop_q);
      REG_LED:  rd_dat = BUS_W'(led_q);
      REG_ID:
      begin
        rd_dat = BOARD_ID;
        rd_err = cmd_i.wen;  // id is read only
      end
      default:  rd_err = 1'b1;  // nothing here
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q  <= 1'b0;
      loop_q <= 1'b0;
      led_q  <= '0;
    end
    else
    begin
      ack_q <= req_i;  // rise and fall one cycle behind req
      if (wr && ofs == REG_LOOP)
        loop_q <= cmd_i.wdata[0];
      if (wr && ofs == REG_LED)
        led_q <= cmd_i.wdata[LED_W-1:0];
    end
  end

  // response captured with ack rise
  always_ff @(posedge adc_clk)
  begin
    if (acc)
      rsp_q <= '{rdata: rd_dat, err: rd_err};
  end

  assign ack_o  = ack_q;
  assign rsp_o  = rsp_q;
  assign loop_o = loop_q;
  assign led_o  = led_q;

endmodule

// File: logic/rp_pkg.sv
/* shared widths, bus region map, register offsets and bus structs
   for the scope and servo core, imported by every design module */
package rp_pkg;

  ////////////////////////////////////////
  // widths and region map
  ////////////////////////////////////////

  localparam int ADC_W       = 14;  // raw and processed sample width
  localparam int BUS_W       = 32;  // bus address and data width
  localparam int NUM_REGIONS = 8;   // address bits 22..20
  localparam int REGION_LSB  = 20;  // lowest bit of region field
  localparam int REGION_HK   = 0;   // housekeeping
  localparam int REGION_CH0  = 1;   // channel n sits at REGION_CH0 + n

  ////////////////////////////////////////
  // register offsets inside a region
  ////////////////////////////////////////

  // channel slave
  localparam logic [REGION_LSB-1:0] REG_OFFSET = 'h00;  // signed offset
  localparam logic [REGION_LSB-1:0] REG_ENABLE = 'h04;  // output enable, bit 0
  // housekeeping slave
  localparam logic [REGION_LSB-1:0] REG_LOOP   = 'h00;  // digital loopback, bit 0
  localparam logic [REGION_LSB-1:0] REG_LED    = 'h04;  // led pattern
  localparam logic [REGION_LSB-1:0] REG_ID     = 'h08;  // read only

  localparam logic [BUS_W-1:0] BOARD_ID = 32'h0A5C_0301;

  // raw ADC/DAC word for a zero sample
  localparam logic [ADC_W-1:0] RAW_ZERO = {1'b0, {(ADC_W-1){1'b1}}};

  typedef logic signed [ADC_W-1:0] sample_t;  // two's complement sample

  typedef struct packed {
    logic [BUS_W-1:0] addr;   // byte address
    logic [BUS_W-1:0] wdata;
    logic             wen;    // 1 write, 0 read
  } bus_req_t;

  typedef struct packed {
    logic [BUS_W-1:0] rdata;
    logic             err;    // unknown offset or illegal write
  } bus_rsp_t;

  // negative slope unsigned <-> two's complement, same map both ways
  function automatic logic [ADC_W-1:0] flip_slope(input logic [ADC_W-1:0] w);
    return {w[ADC_W-1], ~w[ADC_W-2:0]};  // keep sign, invert rest
  endfunction

endpackage

// File: logic/rp_top.sv
/* top level: bus decoder with housekeeping and channel slaves, and the
   adc to channel to dac sample pipeline, all on adc_clk */
module rp_top #(
  parameter int NUM_CH = 2,  // up to 7, region map limit
  parameter int LED_W  = 8
) (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,
  // processor bus, four-phase
  input  logic                                 sys_req_i,
  input  rp_pkg::bus_req_t                     sys_cmd_i,
  output logic                                 sys_ack_o,
  output rp_pkg::bus_rsp_t                     sys_rsp_o,
  // converters
  input  logic [NUM_CH-1:0][rp_pkg::ADC_W-1:0] adc_dat_i,
  output logic [NUM_CH-1:0][rp_pkg::ADC_W-1:0] dac_dat_o,
  output logic [LED_W-1:0]                     led_o
);
  import rp_pkg::*;

  logic [NUM_REGIONS-1:0] slv_req;
  logic [NUM_REGIONS-1:0] slv_ack;
  bus_req_t               slv_cmd;
  bus_rsp_t               slv_rsp [NUM_REGIONS];
  logic                   loop;               // digital loopback
  sample_t                adc_smp [NUM_CH];   // frontend -> channels
  sample_t                ch_res  [NUM_CH];   // channels -> backend

  ////////////////////////////////////////
  // register bus
  ////////////////////////////////////////

  sys_bus_decoder #(.NUM_CH(NUM_CH)) u_dec (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (sys_req_i),
    .cmd_i     (sys_cmd_i),
    .ack_o     (sys_ack_o),
    .rsp_o     (sys_rsp_o),
    .slv_req_o (slv_req),
    .slv_cmd_o (slv_cmd),
    .slv_ack_i (slv_ack),
    .slv_rsp_i (slv_rsp)
  );

  housekeeping_regs #(.LED_W(LED_W)) u_hk (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (slv_req[REGION_HK]),
    .cmd_i   (slv_cmd),
    .ack_o   (slv_ack[REGION_HK]),
    .rsp_o   (slv_rsp[REGION_HK]),
    .loop_o  (loop),
    .led_o   (led_o)
  );

  // empty regions, decoder answers these itself
  for (genvar r = REGION_CH0 + NUM_CH; r < NUM_REGIONS; r++)
  begin : g_empty
    assign slv_ack[r] = 1'b0;
    assign slv_rsp[r] = '0;
  end

  ////////////////////////////////////////
  // sample pipeline
  ////////////////////////////////////////

  adc_frontend #(.NUM_CH(NUM_CH)) u_adc (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .raw_i   (adc_dat_i),
    .smp_o   (adc_smp)
  );

  for (genvar ch = 0; ch < NUM_CH; ch++)
  begin : g_ch
    channel_path u_ch (
      .adc_clk (adc_clk),
      .rst_n_i (rst_n_i),
      .req_i   (slv_req[REGION_CH0 + ch]),
      .cmd_i   (slv_cmd),
      .ack_o   (slv_ack[REGION_CH0 + ch]),
      .rsp_o   (slv_rsp[REGION_CH0 + ch]),
      .loop_i  (loop),
      .smp_i   (adc_smp[ch]),
      .res_o   (ch_res[ch])   // also fed back inside for loopback
    );
  end

  dac_backend #(.NUM_CH(NUM_CH)) u_dac (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .res_i   (ch_res),
    .raw_o   (dac_dat_o)
  );

endmodule

// File: logic/sys_bus_decoder.sv
/* splits the processor bus into eight regions by address bits 22..20,
   runs the four-phase req/ack towards the selected slave */
module sys_bus_decoder #(
  parameter int NUM_CH = 2  // mapped channel regions after housekeeping
) (
  input  logic                             adc_clk,
  input  logic                             rst_n_i,
  // master side
  input  logic                             req_i,
  input  rp_pkg::bus_req_t                 cmd_i,
  output logic                             ack_o,
  output rp_pkg::bus_rsp_t                 rsp_o,
  // slave side, one bit per region
  output logic [rp_pkg::NUM_REGIONS-1:0]   slv_req_o,
  output rp_pkg::bus_req_t                 slv_cmd_o,
  input  logic [rp_pkg::NUM_REGIONS-1:0]   slv_ack_i,
  input  rp_pkg::bus_rsp_t                 slv_rsp_i [rp_pkg::NUM_REGIONS]
);
  import rp_pkg::*;

  localparam int RGN_W   = $clog2(NUM_REGIONS);
  localparam int MAP_CNT = REGION_CH0 + NUM_CH;  // regions with a slave
  // low MAP_CNT bits set
  localparam logic [NUM_REGIONS-1:0] MAP_MASK =
    {NUM_REGIONS{1'b1}} >> (NUM_REGIONS - MAP_CNT);

  logic [RGN_W-1:0]       cmd_rgn;     // region of incoming command
  logic [RGN_W-1:0]       rgn_q;       // region held for whole access
  logic [NUM_REGIONS-1:0] sel_q;       // one-hot, high while req held
  logic                   umap_ack_q;  // own ack for empty regions
  logic                   busy;
  logic                   mapped;

  assign cmd_rgn = cmd_i.addr[REGION_LSB +: RGN_W];
  assign busy    = |sel_q;
  assign mapped  = MAP_MASK[rgn_q];

  ////////////////////////////////////////
  // access tracking
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rgn_q      <= '0;
      sel_q      <= '0;
      umap_ack_q <= 1'b0;
    end
    else
    begin
      if (!req_i)
        sel_q <= '0;  // master released, slave drops ack next cycle
      else if (!busy && !ack_o)
      begin
        // new access only once previous ack is gone
        rgn_q <= cmd_rgn;
        sel_q <= {{(NUM_REGIONS-1){1'b0}}, 1'b1} << cmd_rgn;
      end
      umap_ack_q <= |(sel_q & ~MAP_MASK);  // one cycle behind sel, like a slave
    end
  end

  // req only to regions that have a slave
  assign slv_req_o = sel_q & MAP_MASK;
  assign slv_cmd_o = cmd_i;  // broadcast, stable while req high

  ////////////////////////////////////////
  // response steering
  ////////////////////////////////////////

  always_comb
  begin
    if (mapped)
    begin
      ack_o = slv_ack_i[rgn_q];
      rsp_o = slv_rsp_i[rgn_q];
    end
    else
    begin
      ack_o = umap_ack_q;
      rsp_o = '0;  // empty slot reads zero, no err
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build the rp_top testbench with Verilator, run it, then look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rp_top -f sim.f -Mdir obj_dir -o tb_rp_top
./obj_dir/tb_rp_top | tee sim.log
grep -q "Verification passed" sim.log

// File: sim.f
logic/rp_pkg.sv
logic/sys_bus_decoder.sv
logic/housekeeping_regs.sv
logic/adc_frontend.sv
logic/channel_path.sv
logic/dac_backend.sv
logic/rp_top.sv
sim/rp_top_properties.sv
sim/tb_rp_top.sv

// File: sim/rp_top_properties.sv
/* concurrent checks on the top-level four-phase handshake and on the
   reset state of ack, bound into rp_top */
module rp_top_properties (
  input logic adc_clk,
  input logic rst_n_i,
  input logic req_i,   // sys_req_i of the bound top
  input logic ack_i    // sys_ack_o of the bound top
);
  timeunit 1ns;
  timeprecision 1ps;

  // no ack while reset held
  a_ack_in_reset: assert property (@(posedge adc_clk) !rst_n_i |-> !ack_i)
    else $error("sys_ack_o high while reset is asserted");

  // master keeps req until slave answers
  a_req_held: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    req_i && !ack_i |=> req_i)
    else $error("sys_req_i dropped before sys_ack_o rose");

  // ack stays up as long as req does
  a_ack_after_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ack_i && req_i |=> ack_i)
    else $error("sys_ack_o fell while sys_req_i was still high");

endmodule

bind rp_top rp_top_properties u_props (
  .adc_clk (adc_clk),
  .rst_n_i (rst_n_i),
  .req_i   (sys_req_i),
  .ack_i   (sys_ack_o)
);

// File: sim/tb_rp_top.sv
/* testbench for rp_top: xorshift stimulus on the register bus and ADC pins,
   checked against a model of the registers, conversions and saturation */
module tb_rp_top;
  timeunit 1ns;
  timeprecision 1ps;
  import rp_pkg::*;

  localparam int NUM_CH   = 2;
  localparam int LED_W    = 8;
  localparam int N_RW     = 40;   // random register accesses
  localparam int N_STREAM = 64;   // samples per stream run
  localparam int N_LOOP   = 40;   // loopback cycles checked
  localparam int SMP_MAX  = 2**(ADC_W-1) - 1;
  // about 6 cycles per access, 7 stream runs, then doubled
  localparam int LIMIT = 2 * (10 + 6 * (2 * N_RW + 60) + 7 * N_STREAM + N_LOOP);

  logic                         adc_clk;
  logic                         rst_n_i;
  logic                         sys_req_i;
  logic                         sys_ack_o;
  bus_req_t                     sys_cmd_i;
  bus_rsp_t                     sys_rsp_o;
  logic [NUM_CH-1:0][ADC_W-1:0] adc_dat_i;
  logic [NUM_CH-1:0][ADC_W-1:0] dac_dat_o;
  logic [LED_W-1:0]             led_o;

  int          off_m [NUM_CH];  // model offsets
  logic        en_m  [NUM_CH];  // model enables
  logic [31:0] rng     = 32'd44;
  int          cyc     = 0;     // rising edges since start
  int          err_cnt = 0;
  int          chk_cnt = 0;

  rp_top #(.NUM_CH(NUM_CH), .LED_W(LED_W)) u_rp_top (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .sys_req_i (sys_req_i),
    .sys_cmd_i (sys_cmd_i),
    .sys_ack_o (sys_ack_o),
    .sys_rsp_o (sys_rsp_o),
    .adc_dat_i (adc_dat_i),
    .dac_dat_o (dac_dat_o),
    .led_o     (led_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 10 ns
  end

  always @(posedge adc_clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);  // xorshift32
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [ADC_W-1:0] rand_word();
    logic [31:0] r;
    r = next_rand();
    if (r[3:0] == 4'd0)
      return '0;  // raw word of the max sample
    if (r[3:0] == 4'd1)
      return '1;  // raw word of the min sample
    return r[ADC_W+3:4];
  endfunction

  function automatic logic [31:0] reg_addr(input int rgn, input logic [19:0] ofs);
    return (32'(rgn) << REGION_LSB) | {12'd0, ofs};
  endfunction

  // negative slope raw word <-> signed value, sign bit kept
  function automatic int to_int(input logic [ADC_W-1:0] raw);
    logic signed [ADC_W-1:0] s;
    s = raw ^ 14'h1FFF;
    return int'(s);
  endfunction

  function automatic logic [ADC_W-1:0] to_raw(input int v);
    logic [ADC_W-1:0] t;
    t = v[ADC_W-1:0];
    return t ^ 14'h1FFF;
  endfunction

  function automatic int sat(input int v);
    if (v > SMP_MAX)
      return SMP_MAX;
    if (v < -SMP_MAX - 1)
      return -SMP_MAX - 1;
    return v;
  endfunction

  function automatic logic [ADC_W-1:0] model_dac(input int ch, input logic [ADC_W-1:0] raw);
    if (!en_m[ch])
      return to_raw(0);  // disabled channel sits at mid scale
    return to_raw(sat(to_int(raw) + off_m[ch]));
  endfunction

  ////////////////////////////////////////
  // checks and bus tasks
  ////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp)
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one four-phase access, ack_cyc is the edge count when ack was seen
  task automatic bus_access(input logic [31:0] addr, input logic wen, input logic [31:0] wdata,
                            output logic [31:0] rd, output logic err, output int ack_cyc);
    int req_cyc;  // edge that launched req
    @(posedge adc_clk);
    sys_req_i <= 1'b1;
    sys_cmd_i <= '{addr: addr, wdata: wdata, wen: wen};
    @(negedge adc_clk);
    req_cyc = cyc;
    while (!sys_ack_o)
      @(negedge adc_clk);
    ack_cyc = cyc;
    rd      = sys_rsp_o.rdata;
    err     = sys_rsp_o.err;
    check("ack latency", 32'(ack_cyc - req_cyc), 32'd2);  // two edges from req to ack
    @(posedge adc_clk);
    sys_req_i <= 1'b0;
    @(negedge adc_clk);
    while (sys_ack_o)
      @(negedge adc_clk);  // phase 4 before next request
  endtask

  task automatic xfer(input logic [31:0] addr, input logic wen, input logic [31:0] wdata,
                      input logic exp_err, input string what, output logic [31:0] rd);
    logic err;
    int   c;
    bus_access(addr, wen, wdata, rd, err, c);
    check({what, " err"}, 32'(err), 32'(exp_err));
  endtask

  task automatic wr_rd(input logic [31:0] addr, input logic [31:0] w, input logic [31:0] exp,
                       input string what);
    logic [31:0] rd;
    xfer(addr, 1'b1, w, 1'b0, what, rd);
    xfer(addr, 1'b0, '0, 1'b0, what, rd);
    check(what, rd, exp);
  endtask

  task automatic set_chan(input int ch, input int off, input logic en);
    logic [31:0] rd;
    xfer(reg_addr(REGION_CH0 + ch, REG_OFFSET), 1'b1, 32'(off), 1'b0, "offset", rd);
    xfer(reg_addr(REGION_CH0 + ch, REG_ENABLE), 1'b1, 32'(en), 1'b0, "enable", rd);
    off_m[ch] = off;
    en_m[ch]  = en;
  endtask

  task automatic set_loop(input logic v);
    logic [31:0] rd;
    xfer(reg_addr(REGION_HK, REG_LOOP), 1'b1, 32'(v), 1'b0, "loop", rd);
  endtask

  ////////////////////////////////////////
  // test sequences
  ////////////////////////////////////////

  task automatic reg_test();
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] rd;
    int          ch;
    for (int i = 0; i < N_RW; i++)
    begin
      r  = next_rand();
      w  = next_rand();
      ch = int'(r[3]) % NUM_CH;
      case (r[2:0])
        3'd0, 3'd1:
        begin
          off_m[ch] = int'($signed(w[ADC_W-1:0]));
          wr_rd(reg_addr(REGION_CH0 + ch, REG_OFFSET), w, 32'(off_m[ch]), "offset");
        end
        3'd2, 3'd3:
        begin
          en_m[ch] = w[0];
          wr_rd(reg_addr(REGION_CH0 + ch, REG_ENABLE), w, 32'(w[0]), "enable");
        end
        3'd4:
        begin
          wr_rd(reg_addr(REGION_HK, REG_LED), w, 32'(w[LED_W-1:0]), "led");
          check("led_o", 32'(led_o), 32'(w[LED_W-1:0]));
        end
        default: wr_rd(reg_addr(REGION_HK, REG_LOOP), w, 32'(w[0]), "loop");
      endcase
    end
    xfer(reg_addr(REGION_HK, REG_ID), 1'b0, '0, 1'b0, "id", rd);
    check("id", rd, BOARD_ID);
    xfer(reg_addr(REGION_HK, REG_ID), 1'b1, next_rand(), 1'b1, "id write", rd);
    xfer(reg_addr(REGION_HK, REG_ID), 1'b0, '0, 1'b0, "id", rd);
    check("id after write", rd, BOARD_ID);  // write had no effect
    xfer(reg_addr(REGION_HK, 20'h0C), 1'b0, '0, 1'b1, "hk unknown", rd);
    for (int c = 0; c < NUM_CH; c++)
      xfer(reg_addr(REGION_CH0 + c, 20'h08), 1'b1, '0, 1'b1, "ch unknown", rd);
    // empty slots answer zero
    for (int rgn = REGION_CH0 + NUM_CH; rgn < NUM_REGIONS; rgn++)
    begin
      r = next_rand();
      xfer(reg_addr(rgn, r[27:8]), r[7], next_rand(), 1'b0, "unmapped", rd);
      check("unmapped rdata", rd, '0);
    end
  endtask

  // random ADC words, each one checked 3 cycles later on the DAC pins
  task automatic stream(input int n);
    logic [NUM_CH-1:0][ADC_W-1:0] hist [$];
    logic [NUM_CH-1:0][ADC_W-1:0] word;
    for (int i = 0; i < n; i++)
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
        word[ch] = rand_word();
      @(posedge adc_clk);
      adc_dat_i <= word;
      hist.push_back(word);
      @(negedge adc_clk);
      if (i >= 3)
        for (int ch = 0; ch < NUM_CH; ch++)
          check($sformatf("dac ch%0d", ch), 32'(dac_dat_o[ch]),
                32'(model_dac(ch, hist[i-3][ch])));
    end
  endtask

  task automatic loop_test();
    int          off [NUM_CH];
    int          en_cyc [NUM_CH];  // edge of the enable write
    int          k;
    logic [31:0] rd;
    logic        err;
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      off[ch] = 300 + int'(next_rand() % 300);
      set_chan(ch, off[ch], 1'b0);  // result held at 0
    end
    set_loop(1'b1);
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      bus_access(reg_addr(REGION_CH0 + ch, REG_ENABLE), 1'b1, 32'd1, rd, err, en_cyc[ch]);
      check("enable err", 32'(err), '0);
      en_m[ch] = 1'b1;
    end
    for (int i = 0; i < N_LOOP; i++)
    begin
      @(posedge adc_clk);
      for (int ch = 0; ch < NUM_CH; ch++)
        adc_dat_i[ch] <= rand_word();  // must not reach the output
      @(negedge adc_clk);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
        k = cyc - en_cyc[ch];  // pin shows result from one edge earlier
        check($sformatf("loop ch%0d", ch), 32'(dac_dat_o[ch]),
              32'(to_raw(sat((k - 1) * off[ch]))));
      end
    end
    set_loop(1'b0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    int          off;
    rst_n_i   <= 1'b0;
    sys_req_i <= 1'b0;
    sys_cmd_i <= '0;
    adc_dat_i <= '0;
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      off_m[ch] = 0;
      en_m[ch]  = 1'b0;
    end
    repeat (10) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    @(negedge adc_clk);
    for (int ch = 0; ch < NUM_CH; ch++)
      check("dac after reset", 32'(dac_dat_o[ch]), 32'h1FFF);
    check("led after reset", 32'(led_o), '0);
    reg_test();
    set_loop(1'b0);
    for (int ch = 0; ch < NUM_CH; ch++)
      set_chan(ch, 0, 1'b1);  // plain pass-through
    stream(N_STREAM);
    // full-scale offsets first so both clamps are hit
    for (int rnd = 0; rnd < 4; rnd++)
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
        r   = next_rand();
        off = (rnd == 0) ? SMP_MAX : (rnd == 1) ? -SMP_MAX - 1 : int'($signed(r[ADC_W-1:0]));
        set_chan(ch, off, 1'b1);
      end
      stream(N_STREAM);
    end
    loop_test();
    // one channel disabled at a time
    for (int dis = 0; dis < NUM_CH; dis++)
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
        r = next_rand();
        set_chan(ch, int'($signed(r[ADC_W-1:0])), ch != dis);
      end
      stream(N_STREAM);
    end
    $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule
